// File: hdl/cu_pkg.sv
`default_nettype none

package cu_pkg;

	// --------------------------------------------------
	// Widths and sizes
	// --------------------------------------------------

	// Memory data word
	localparam int CU_DATA_WIDTH = 32;
	// Memory address, also a neighbor ID
	localparam int CU_ADDR_WIDTH = 32;

	// Largest vertex degree, doubles as neighbor FIFO depth
	localparam int CU_MAX_DEGREE = 16;
	// Holds 0 to 16
	localparam int CU_DEGREE_WIDTH = 5;
	// FIFO pointers wrap on their own since depth is a power of two
	localparam int CU_FIFO_PTR_WIDTH = $clog2(CU_MAX_DEGREE);

	// Response demux lanes
	localparam int CU_LANE_EDGE = 0;
	localparam int CU_LANE_DATA = 1;

	// --------------------------------------------------
	// Enums
	// --------------------------------------------------

	// Which array a request or response belongs to
	// Only EDGE_ARRAY_DEST and READ_GRAPH_DATA are issued here
	typedef enum logic [2:0] {
		STRUCT_INVALID,
		EDGE_ARRAY_DEST,
		READ_GRAPH_DATA,
		READ_GRAPH_DATA_SRC,
		READ_GRAPH_DATA_DEST,
		READ_GRAPH_DATA_HIGH
	} array_struct_type;

	// Gather control states
	typedef enum logic [1:0] {
		IDLE,
		EDGE_READ,
		DATA_WAIT,
		FINISH
	} gather_state_type;

	// --------------------------------------------------
	// Memory port structs
	// --------------------------------------------------

	// Read request, taken by memory whenever valid is high
	typedef struct packed {
		logic                     valid;
		array_struct_type         tag;
		logic [0:CU_ADDR_WIDTH-1] address;
	} mem_request_type;

	// Read response, carries the tag of its request
	typedef struct packed {
		logic                     valid;
		array_struct_type         tag;
		logic [0:CU_DATA_WIDTH-1] data;
	} mem_response_type;

endpackage

`default_nettype wire

// File: hdl/array_struct_type_demux_bus.sv
`timescale 1ns/1ps
`default_nettype none

module array_struct_type_demux_bus (
	input  logic                             clock,
	input  logic                             rstn,
	input  cu_pkg::array_struct_type         sel_in,
	input  logic [0:cu_pkg::CU_DATA_WIDTH-1] data_in,
	input  logic                             data_in_valid,
	output logic [0:cu_pkg::CU_DATA_WIDTH-1] data_out [0:1],
	output logic                             data_out_valid [0:1]
);

	import cu_pkg::*;

	// Stage 1 registers
	array_struct_type         sel_in_latched;
	logic [0:CU_DATA_WIDTH-1] data_in_latched;
	logic                     data_in_valid_latched;

	// Stage 2 registers
	logic                     lane_valid_internal [0:1];
	logic [0:CU_DATA_WIDTH-1] data_internal;

	// --------------------------------------------------
	// Input latch
	// --------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_in_valid_latched <= 1'b0;
			sel_in_latched        <= STRUCT_INVALID;
		end else begin
			data_in_valid_latched <= data_in_valid;
			sel_in_latched        <= sel_in;
		end
	end

	// Payload only
	always_ff @(posedge clock) begin
		data_in_latched <= data_in;
	end

	// --------------------------------------------------
	// Lane select by tag
	// --------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lane_valid_internal[CU_LANE_EDGE] <= 1'b0;
			lane_valid_internal[CU_LANE_DATA] <= 1'b0;
		end else begin
			case (sel_in_latched)
				EDGE_ARRAY_DEST: begin
					lane_valid_internal[CU_LANE_EDGE] <= data_in_valid_latched;
					lane_valid_internal[CU_LANE_DATA] <= 1'b0;
				end
				// Every graph data kind shares the data lane
				READ_GRAPH_DATA, READ_GRAPH_DATA_SRC,
				READ_GRAPH_DATA_DEST, READ_GRAPH_DATA_HIGH: begin
					lane_valid_internal[CU_LANE_EDGE] <= 1'b0;
					lane_valid_internal[CU_LANE_DATA] <= data_in_valid_latched;
				end
				// Invalid tag dropped
				default: begin
					lane_valid_internal[CU_LANE_EDGE] <= 1'b0;
					lane_valid_internal[CU_LANE_DATA] <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		data_internal <= data_in_latched;
	end

	// --------------------------------------------------
	// Output registers
	// --------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_out_valid[CU_LANE_EDGE] <= 1'b0;
			data_out_valid[CU_LANE_DATA] <= 1'b0;
		end else begin
			data_out_valid[CU_LANE_EDGE] <= lane_valid_internal[CU_LANE_EDGE];
			data_out_valid[CU_LANE_DATA] <= lane_valid_internal[CU_LANE_DATA];
		end
	end

	// Both lanes see the same word
	always_ff @(posedge clock) begin
		data_out[CU_LANE_EDGE] <= data_internal;
		data_out[CU_LANE_DATA] <= data_internal;
	end

endmodule

`default_nettype wire

// File: hdl/neighbor_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_fifo (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic                             push,
	input  logic [0:cu_pkg::CU_ADDR_WIDTH-1] push_data,
	input  logic                             pop,
	output logic [0:cu_pkg::CU_ADDR_WIDTH-1] pop_data,
	output logic                             empty
);

	import cu_pkg::*;

	// Neighbor ID storage
	logic [0:CU_ADDR_WIDTH-1]     entries [0:CU_MAX_DEGREE-1];
	logic [0:CU_FIFO_PTR_WIDTH-1] wr_ptr;
	logic [0:CU_FIFO_PTR_WIDTH-1] rd_ptr;
	// Occupancy, 0 to 16
	logic [0:CU_DEGREE_WIDTH-1]   count;

	// --------------------------------------------------
	// Storage write
	// --------------------------------------------------

	always_ff @(posedge clock) begin
		if (push) begin
			entries[wr_ptr] <= push_data;
		end
	end

	// --------------------------------------------------
	// Pointers and occupancy
	// --------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop keeps count
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Head entry, no read latency
	assign pop_data = entries[rd_ptr];
	assign empty    = (count == '0);

endmodule

`default_nettype wire

// File: hdl/read_request_mux.sv
`timescale 1ns/1ps
`default_nettype none

module read_request_mux (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic                             edge_issue,
	input  logic [0:cu_pkg::CU_ADDR_WIDTH-1] edge_address,
	input  logic                             fifo_empty,
	input  logic [0:cu_pkg::CU_ADDR_WIDTH-1] fifo_data,
	output logic                             fifo_pop,
	output cu_pkg::mem_request_type          mem_request
);

	import cu_pkg::*;

	// Registered request fields
	logic                     request_valid;
	array_struct_type         request_tag;
	logic [0:CU_ADDR_WIDTH-1] request_address;

	// Edge reads first, queued data reads fill idle slots
	assign fifo_pop = !fifo_empty && !edge_issue;

	// --------------------------------------------------
	// Request register
	// --------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			request_valid <= 1'b0;
			request_tag   <= STRUCT_INVALID;
		end else if (edge_issue) begin
			request_valid <= 1'b1;
			request_tag   <= EDGE_ARRAY_DEST;
		end else if (fifo_pop) begin
			request_valid <= 1'b1;
			request_tag   <= READ_GRAPH_DATA;
		end else begin
			request_valid <= 1'b0;
			request_tag   <= STRUCT_INVALID;
		end
	end

	// Address follows the chosen source
	always_ff @(posedge clock) begin
		if (edge_issue) begin
			request_address <= edge_address;
		end else if (fifo_pop) begin
			// Neighbor ID is the graph data address
			request_address <= fifo_data;
		end
	end

	assign mem_request.valid   = request_valid;
	assign mem_request.tag     = request_tag;
	assign mem_request.address = request_address;

endmodule

`default_nettype wire

// File: hdl/vertex_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_accumulator (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic                             clear,
	input  logic                             add_valid,
	input  logic [0:cu_pkg::CU_DATA_WIDTH-1] add_data,
	output logic [0:cu_pkg::CU_DATA_WIDTH-1] sum
);

	// --------------------------------------------------
	// Running sum
	// --------------------------------------------------

	// Clear wins over add
	// Carry out of the top bit dropped, so the sum wraps
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum <= '0;
		end else if (clear) begin
			sum <= '0;
		end else if (add_valid) begin
			sum <= sum + add_data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/gather_control.sv
`timescale 1ns/1ps
`default_nettype none

module gather_control (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               start,
	input  logic [0:cu_pkg::CU_ADDR_WIDTH-1]   edge_offset,
	input  logic [0:cu_pkg::CU_DEGREE_WIDTH-1] degree,
	input  logic                               edge_response,
	input  logic                               data_response,
	output logic                               edge_issue,
	output logic [0:cu_pkg::CU_ADDR_WIDTH-1]   edge_address,
	output logic                               clear,
	output logic                               busy,
	output logic                               done
);

	import cu_pkg::*;

	gather_state_type state;
	gather_state_type next_state;

	// Degree of the current vertex
	logic [0:CU_DEGREE_WIDTH-1] degree_latched;
	// Edge reads issued so far
	logic [0:CU_DEGREE_WIDTH-1] issue_count;
	// Graph data responses seen so far
	logic [0:CU_DEGREE_WIDTH-1] data_count;
	// Edge reads without a response yet
	logic [0:CU_DEGREE_WIDTH-1] edge_pending;

	logic accept_start;
	logic last_issue;
	logic all_returned;

	// Start only taken while idle
	assign accept_start = (state == IDLE) && start;
	assign last_issue   = (issue_count == degree_latched - 1'b1);
	assign all_returned = (data_count == degree_latched) && (edge_pending == '0);

	// --------------------------------------------------
	// State machine
	// --------------------------------------------------

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (accept_start) begin
					// Degree zero skips all reads
					if (degree == '0) begin
						next_state = FINISH;
					end else begin
						next_state = EDGE_READ;
					end
				end
			end
			EDGE_READ: begin
				if (last_issue) begin
					next_state = DATA_WAIT;
				end
			end
			DATA_WAIT: begin
				if (all_returned) begin
					next_state = FINISH;
				end
			end
			FINISH: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// --------------------------------------------------
	// Counters and edge address
	// --------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			degree_latched <= '0;
			issue_count    <= '0;
			edge_address   <= '0;
		end else if (accept_start) begin
			degree_latched <= degree;
			issue_count    <= '0;
			edge_address   <= edge_offset;
		end else if (edge_issue) begin
			// Consecutive edge array entries
			issue_count  <= issue_count + 1'b1;
			edge_address <= edge_address + 1'b1;
		end
	end

	// Data responses only count while busy
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_count <= '0;
		end else if (accept_start) begin
			data_count <= '0;
		end else if (busy && data_response) begin
			data_count <= data_count + 1'b1;
		end
	end

	// Up on issue, down on response
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_pending <= '0;
		end else if (edge_issue && !edge_response) begin
			edge_pending <= edge_pending + 1'b1;
		end else if (edge_response && !edge_issue) begin
			edge_pending <= edge_pending - 1'b1;
		end
	end

	// Outputs decoded from state
	assign edge_issue = (state == EDGE_READ);
	assign busy       = (state == EDGE_READ) || (state == DATA_WAIT);
	assign done       = (state == FINISH);
	assign clear      = accept_start;

endmodule

`default_nettype wire

// File: hdl/vertex_gather_top.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_gather_top (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               start,
	input  logic [0:cu_pkg::CU_ADDR_WIDTH-1]   edge_offset,
	input  logic [0:cu_pkg::CU_DEGREE_WIDTH-1] degree,
	output cu_pkg::mem_request_type            mem_request,
	input  cu_pkg::mem_response_type           mem_response,
	output logic                               busy,
	output logic                               done,
	output logic [0:cu_pkg::CU_DATA_WIDTH-1]   sum
);

	import cu_pkg::*;

	// Control to request mux
	logic                     edge_issue;
	logic [0:CU_ADDR_WIDTH-1] edge_address;
	logic                     clear;

	// Neighbor queue
	logic                     fifo_pop;
	logic                     fifo_empty;
	logic [0:CU_ADDR_WIDTH-1] fifo_data;

	// Demux lanes
	logic [0:CU_DATA_WIDTH-1] lane_data  [0:1];
	logic                     lane_valid [0:1];

	gather_control control (
		.clock        (clock),
		.rstn         (rstn),
		.start        (start),
		.edge_offset  (edge_offset),
		.degree       (degree),
		.edge_response(lane_valid[CU_LANE_EDGE]),
		.data_response(lane_valid[CU_LANE_DATA]),
		.edge_issue   (edge_issue),
		.edge_address (edge_address),
		.clear        (clear),
		.busy         (busy),
		.done         (done)
	);

	read_request_mux request_mux (
		.clock       (clock),
		.rstn        (rstn),
		.edge_issue  (edge_issue),
		.edge_address(edge_address),
		.fifo_empty  (fifo_empty),
		.fifo_data   (fifo_data),
		.fifo_pop    (fifo_pop),
		.mem_request (mem_request)
	);

	// Edge lane feeds neighbor IDs into the queue
	neighbor_fifo neighbors (
		.clock    (clock),
		.rstn     (rstn),
		.push     (lane_valid[CU_LANE_EDGE]),
		.push_data(lane_data[CU_LANE_EDGE]),
		.pop      (fifo_pop),
		.pop_data (fifo_data),
		.empty    (fifo_empty)
	);

	array_struct_type_demux_bus response_demux (
		.clock         (clock),
		.rstn          (rstn),
		.sel_in        (mem_response.tag),
		.data_in       (mem_response.data),
		.data_in_valid (mem_response.valid),
		.data_out      (lane_data),
		.data_out_valid(lane_valid)
	);

	// Graph data lane into the sum
	vertex_accumulator accumulator (
		.clock    (clock),
		.rstn     (rstn),
		.clear    (clear),
		.add_valid(lane_valid[CU_LANE_DATA]),
		.add_data (lane_data[CU_LANE_DATA]),
		.sum      (sum)
	);

endmodule

`default_nettype wire

// File: testbench/vertex_gather_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_gather_tb;

	import cu_pkg::*;

	// Every address used stays below the modeled memory size
	localparam int MEM_WORDS     = 256;
	// Random response delays drawn once after seeding
	localparam int DELAY_ENTRIES = 64;
	localparam int DONE_TIMEOUT  = 1000;
	localparam int SEND_TIMEOUT  = 50;

	logic                       clock;
	logic                       rstn;
	logic                       start;
	logic [0:CU_ADDR_WIDTH-1]   edge_offset;
	logic [0:CU_DEGREE_WIDTH-1] degree;
	mem_request_type            mem_request;
	mem_response_type           mem_response = '0;
	logic                       busy;
	logic                       done;
	logic [0:CU_DATA_WIDTH-1]   sum;

	// Memory contents
	logic [0:CU_DATA_WIDTH-1] edge_mem [0:MEM_WORDS-1];
	logic [0:CU_DATA_WIDTH-1] data_mem [0:MEM_WORDS-1];
	int unsigned              delay_table [0:DELAY_ENTRIES-1];

	// Pending responses and their due cycles
	mem_response_type response_queue [$];
	int unsigned      due_queue [$];
	// Every valid request seen on the port
	mem_request_type  request_log [$];

	// Stray response injection
	logic                     stray_inject;
	logic [0:CU_DATA_WIDTH-1] stray_data;

	vertex_gather_top uut (
		.clock       (clock),
		.rstn        (rstn),
		.start       (start),
		.edge_offset (edge_offset),
		.degree      (degree),
		.mem_request (mem_request),
		.mem_response(mem_response),
		.busy        (busy),
		.done        (done),
		.sum         (sum)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// --------------------------------------------------
	// Memory model
	// --------------------------------------------------

	// Answers in request order with the request tag after 2 to 8 cycles
	always @(posedge clock) begin : memory_model
		int unsigned      model_cycle;
		int unsigned      last_due;
		int unsigned      request_number;
		int unsigned      index;
		int unsigned      due;
		mem_response_type reply;
		if (!rstn) begin
			mem_response   <= '0;
			model_cycle    = 0;
			last_due       = 0;
			request_number = 0;
		end else begin
			model_cycle = model_cycle + 1;
			// At most one response per cycle
			if (due_queue.size() > 0 && due_queue[0] <= model_cycle) begin
				mem_response <= response_queue.pop_front();
				void'(due_queue.pop_front());
			end else begin
				mem_response <= '0;
			end
			if (mem_request.valid) begin
				request_log.push_back(mem_request);
				index = mem_request.address;
				if (index >= MEM_WORDS) begin
					$display("memory request outside the modeled memory at address %h",
						mem_request.address);
					abort_run();
				end
				reply.valid = 1'b1;
				reply.tag   = mem_request.tag;
				if (mem_request.tag == EDGE_ARRAY_DEST) begin
					reply.data = edge_mem[index];
				end else begin
					reply.data = data_mem[index];
				end
				due = model_cycle + delay_table[request_number % DELAY_ENTRIES];
				// Keep answers in request order
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due       = due;
				request_number = request_number + 1;
				response_queue.push_back(reply);
				due_queue.push_back(due);
			end
			if (stray_inject) begin
				reply.valid = 1'b1;
				reply.tag   = STRUCT_INVALID;
				reply.data  = stray_data;
				due         = model_cycle + 2;
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				response_queue.push_back(reply);
				due_queue.push_back(due);
			end
		end
	end

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_request(input string name, input mem_request_type actual,
		input mem_request_type expected);
		if (actual !== expected) begin
			$display("error: %s actual %h expected %h", name, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_sum(input string name, input logic [0:CU_DATA_WIDTH-1] actual,
		input logic [0:CU_DATA_WIDTH-1] expected);
		if (actual !== expected) begin
			$display("error: %s actual %h expected %h", name, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_level(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("error: %s actual %h expected %h", name, actual, expected);
			abort_run();
		end
	endtask

	// --------------------------------------------------
	// Gather driver
	// --------------------------------------------------

	// ignored_start_at is the wait cycle of a start pulsed while busy or -1 for none
	task automatic run_gather(input logic [0:CU_ADDR_WIDTH-1] offset,
		input logic [0:CU_DEGREE_WIDTH-1] count, input int ignored_start_at);
		logic [0:CU_DATA_WIDTH-1] expected_sum;
		mem_request_type          expected;
		int unsigned              neighbor;
		int                       cycles;
		int                       i;
		// Wrapping sum of the neighbors' graph data
		expected_sum = '0;
		for (i = 0; i < count; i++) begin
			neighbor     = edge_mem[offset + i];
			expected_sum = expected_sum + data_mem[neighbor];
		end
		@(posedge clock);
		// Previous done lasted one cycle
		check_level("done", done, 1'b0);
		request_log.delete();
		start       <= 1'b1;
		edge_offset <= offset;
		degree      <= count;
		@(posedge clock);
		start <= 1'b0;
		cycles = 0;
		@(posedge clock);
		while (!done) begin
			check_level("busy", busy, 1'b1);
			// Start for a different vertex while busy
			if (cycles == ignored_start_at) begin
				start       <= 1'b1;
				edge_offset <= 32'd8;
				degree      <= 5'd9;
			end else begin
				start <= 1'b0;
			end
			cycles++;
			if (cycles > DONE_TIMEOUT) begin
				$display("done never came for the gather at offset %h", offset);
				abort_run();
			end
			@(posedge clock);
		end
		start <= 1'b0;
		// Degree zero finishes in the cycle after start
		if (count == '0 && cycles != 0) begin
			$display("done came %0d cycles late for a degree zero gather", cycles);
			abort_run();
		end
		check_level("busy", busy, 1'b0);
		check_sum("sum", sum, expected_sum);
		// Edge reads in order followed by data reads in edge response order
		for (i = 0; i < 2 * count; i++) begin
			if (i >= request_log.size()) begin
				$display("only %0d memory requests seen, %0d expected",
					request_log.size(), 2 * count);
				abort_run();
			end
			expected.valid = 1'b1;
			if (i < count) begin
				expected.tag     = EDGE_ARRAY_DEST;
				expected.address = offset + i;
			end else begin
				expected.tag     = READ_GRAPH_DATA;
				expected.address = edge_mem[offset + i - count];
			end
			check_request("mem_request", request_log[i], expected);
		end
		if (request_log.size() != 2 * count) begin
			$display("%0d memory requests seen, only %0d expected",
				request_log.size(), 2 * count);
			abort_run();
		end
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------

	task automatic after_reset();
		@(posedge clock);
		check_level("mem_request.valid", mem_request.valid, 1'b0);
		check_level("busy", busy, 1'b0);
		check_level("done", done, 1'b0);
		check_sum("sum", sum, '0);
	endtask

	task automatic degree_four_gather();
		run_gather(32'd40, 5'd4, -1);
	endtask

	// Invalid tag must reach neither lane
	task automatic stray_response();
		logic [0:CU_DATA_WIDTH-1] held_sum;
		int                       cycles;
		@(posedge clock);
		held_sum = sum;
		stray_data   <= 32'hdead_beef;
		stray_inject <= 1'b1;
		@(posedge clock);
		stray_inject <= 1'b0;
		cycles = 0;
		@(posedge clock);
		while (!(mem_response.valid && mem_response.tag == STRUCT_INVALID)) begin
			cycles++;
			if (cycles > SEND_TIMEOUT) begin
				$display("stray response never reached the DUT");
				abort_run();
			end
			@(posedge clock);
		end
		// Demux latency plus the accumulator edge
		// An edge lane push would show up as a data request
		repeat (5) begin
			@(posedge clock);
			check_sum("sum", sum, held_sum);
			check_level("busy", busy, 1'b0);
			check_level("mem_request.valid", mem_request.valid, 1'b0);
		end
	endtask

	// Data near 2^32 so the sum wraps
	task automatic degree_sixteen_gather();
		int unsigned neighbor;
		int          i;
		for (i = 0; i < CU_MAX_DEGREE; i++) begin
			neighbor           = $urandom % MEM_WORDS;
			edge_mem[200 + i]  = neighbor;
			data_mem[neighbor] = 32'hfff0_0000 + ($urandom % 32'h0010_0000);
		end
		run_gather(32'd200, 5'd16, -1);
	endtask

	task automatic degree_zero_gather();
		run_gather(32'd60, 5'd0, -1);
	endtask

	task automatic back_to_back_gathers();
		run_gather(32'd100, 5'd5, -1);
		run_gather(32'd160, 5'd3, 2);
		run_gather(32'd20, 5'd7, 4);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial begin
		int a;
		void'($urandom(8));
		// Fill patterns over the whole address
		for (a = 0; a < MEM_WORDS; a++) begin
			edge_mem[a] = (a * 37 + 11) % MEM_WORDS;
			data_mem[a] = (a * 32'h0101_0101) ^ 32'h5a00_00a5;
		end
		for (a = 0; a < DELAY_ENTRIES; a++) begin
			delay_table[a] = 2 + ($urandom % 7);
		end
		rstn         = 1'b0;
		start        = 1'b0;
		edge_offset  = '0;
		degree       = '0;
		stray_inject = 1'b0;
		stray_data   = '0;
		repeat (16) @(posedge clock);
		rstn <= 1'b1;
		after_reset();
		degree_four_gather();
		stray_response();
		degree_sixteen_gather();
		degree_zero_gather();
		back_to_back_gathers();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hdl/cu_pkg.sv
hdl/array_struct_type_demux_bus.sv
hdl/neighbor_fifo.sv
hdl/read_request_mux.sv
hdl/vertex_accumulator.sv
hdl/gather_control.sv
hdl/vertex_gather_top.sv
testbench/vertex_gather_tb.sv

// File: Bender.yml
package:
  name: vertex_gather

sources:
  # Design, package first
  - files:
      - hdl/cu_pkg.sv
      - hdl/array_struct_type_demux_bus.sv
      - hdl/neighbor_fifo.sv
      - hdl/read_request_mux.sv
      - hdl/vertex_accumulator.sv
      - hdl/gather_control.sv
      - hdl/vertex_gather_top.sv

  # Testbench
  - target: test
    files:
      - testbench/vertex_gather_tb.sv
